// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [4:0] {
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_bge,
		op_lw, op_lbu, op_sb, op_sh, op_sw,
		op_addi, op_sltiu, op_slli, op_add, op_sll,
		op_ebreak, op_illegal
	} op_e;

	localparam logic [2:0] f3_jalr  = 3'b000;
	localparam logic [2:0] f3_beq   = 3'b000;
	localparam logic [2:0] f3_bne   = 3'b001;
	localparam logic [2:0] f3_bge   = 3'b101;
	localparam logic [2:0] f3_lw    = 3'b010;
	localparam logic [2:0] f3_lbu   = 3'b100;
	localparam logic [2:0] f3_sb    = 3'b000;
	localparam logic [2:0] f3_sh    = 3'b001;
	localparam logic [2:0] f3_sw    = 3'b010;
	localparam logic [2:0] f3_addi  = 3'b000;
	localparam logic [2:0] f3_sltiu = 3'b011;
	localparam logic [2:0] f3_slli  = 3'b001;
	localparam logic [2:0] f3_add   = 3'b000;
	localparam logic [2:0] f3_sll   = 3'b001;

	localparam logic [6:0] f7_slli = 7'b0000000;
	localparam logic [6:0] f7_add  = 7'b0000000;
	localparam logic [6:0] f7_sll  = 7'b0000000;

	localparam logic [31:0] ebreak_word  = 32'h0010_0073; // only system word accepted
	localparam logic [31:0] reset_vector = 32'h0000_0000;

endpackage

// File: src/core_pkg.sv
package core_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [2:0] {
		st_fetch,
		st_exec,
		st_mem,
		st_wb,
		st_halt
	} state_e;

	typedef struct packed {
		op_e         op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm; // already sign-extended
	} decoded_t;

	typedef struct packed {
		logic        req;
		logic        wen;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] value;
		logic        wen;
	} commit_t;

endpackage

// File: src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import rv_isa_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        step,
	input  logic        load,
	input  logic [31:0] target,
	output logic [31:0] pc
);

	logic [31:0] next_pc;

	assign next_pc = load ? {target[31:1], 1'b0} : pc + 32'd4; // jalr rule drops bit 0

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= reset_vector;
		end else if (step) begin
			pc <= next_pc;
		end
	end

endmodule

// File: src/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl import rv_isa_pkg::*, core_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  op_e    op,
	output state_e state,
	output logic   instr_latch,
	output logic   pc_step,
	output logic   rf_wen,
	output logic   mem_go,
	output logic   commit_valid,
	output logic   halted,
	output logic   trap
);

	state_e next;
	logic   is_mem;
	logic   writes_rd;
	logic   stop;

	always_comb begin
		is_mem = 1'b0;
		writes_rd = 1'b1;
		case (op)
			op_lw, op_lbu: is_mem = 1'b1;
			op_sb, op_sh, op_sw: begin
				is_mem = 1'b1;
				writes_rd = 1'b0;
			end
			op_beq, op_bne, op_bge, op_ebreak, op_illegal: writes_rd = 1'b0;
			default: is_mem = 1'b0;
		endcase
	end

	assign stop = (op == op_ebreak) || (op == op_illegal);

	always_comb begin
		case (state)
			st_fetch: next = st_exec;
			st_exec: begin
				if (stop)
					next = st_halt; // no commit on this path
				else if (is_mem)
					next = st_mem;
				else
					next = st_wb;
			end
			st_mem:  next = st_wb;
			st_wb:   next = st_fetch;
			default: next = st_halt;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_fetch;
			trap <= 1'b0;
		end else begin
			state <= next;
			if (state == st_exec && op == op_illegal)
				trap <= 1'b1; // sticky until reset
		end
	end

	assign instr_latch  = (state == st_fetch);
	assign mem_go       = (state == st_mem);
	assign pc_step      = (state == st_wb);
	assign commit_valid = (state == st_wb);
	assign rf_wen       = (state == st_wb) && writes_rd;
	assign halted       = (state == st_halt);

endmodule

// File: src/decoder.sv
`timescale 1ns/1ps

module decoder import rv_isa_pkg::*, core_pkg::*; (
	input  logic [31:0] instr,
	output decoded_t    dec
);

	opcode_e     opc;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opc    = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec.op  = op_illegal; // anything not matched below
		dec.rd  = instr[11:7];
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.imm = imm_i;
		case (opc)
			opc_lui: begin
				dec.op = op_lui;
				dec.imm = imm_u;
			end
			opc_auipc: begin
				dec.op = op_auipc;
				dec.imm = imm_u;
			end
			opc_jal: begin
				dec.op = op_jal;
				dec.imm = imm_j;
			end
			opc_jalr: begin
				if (funct3 == f3_jalr)
					dec.op = op_jalr;
			end
			opc_branch: begin
				dec.imm = imm_b;
				case (funct3)
					f3_beq:  dec.op = op_beq;
					f3_bne:  dec.op = op_bne;
					f3_bge:  dec.op = op_bge;
					default: dec.op = op_illegal;
				endcase
			end
			opc_load: begin
				case (funct3)
					f3_lw:   dec.op = op_lw;
					f3_lbu:  dec.op = op_lbu;
					default: dec.op = op_illegal;
				endcase
			end
			opc_store: begin
				dec.imm = imm_s;
				case (funct3)
					f3_sb:   dec.op = op_sb;
					f3_sh:   dec.op = op_sh;
					f3_sw:   dec.op = op_sw;
					default: dec.op = op_illegal;
				endcase
			end
			opc_op_imm: begin
				if (funct3 == f3_addi)
					dec.op = op_addi;
				else if (funct3 == f3_sltiu)
					dec.op = op_sltiu;
				else if (funct3 == f3_slli && funct7 == f7_slli)
					dec.op = op_slli;
			end
			opc_op: begin
				if (funct3 == f3_add && funct7 == f7_add)
					dec.op = op_add;
				else if (funct3 == f3_sll && funct7 == f7_sll)
					dec.op = op_sll;
			end
			opc_system: begin
				if (instr == ebreak_word)
					dec.op = op_ebreak;
			end
			default: dec.op = op_illegal;
		endcase
	end

endmodule

// File: src/exu.sv
`timescale 1ns/1ps

module exu import rv_isa_pkg::*, core_pkg::*; (
	input  decoded_t    dec,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] pc,
	input  logic [31:0] rdata,
	output logic [31:0] value,
	output logic        taken,
	output logic [31:0] target,
	output mem_req_t    mem
);

	logic [31:0] base_imm;
	logic [31:0] pc_imm;
	logic [31:0] link;

	assign base_imm = src1 + dec.imm; // jalr target and load/store address
	assign pc_imm   = pc + dec.imm;
	assign link     = pc + 32'd4;

	always_comb begin
		case (dec.op)
			op_lui:          value = dec.imm;
			op_auipc:        value = pc_imm;
			op_jal, op_jalr: value = link;
			op_lw:           value = rdata;
			op_lbu:          value = {24'b0, rdata[{base_imm[1:0], 3'b000} +: 8]}; // addressed byte
			op_addi:         value = base_imm;
			op_sltiu:        value = {31'b0, src1 < dec.imm}; // unsigned compare
			op_slli:         value = src1 << dec.imm[4:0];
			op_add:          value = src1 + src2;
			op_sll:          value = src1 << src2[4:0];
			default:         value = '0;
		endcase
	end

	always_comb begin
		target = pc_imm;
		case (dec.op)
			op_beq: taken = (src1 == src2);
			op_bne: taken = (src1 != src2);
			op_bge: taken = ($signed(src1) >= $signed(src2));
			op_jal: taken = 1'b1;
			op_jalr: begin
				taken = 1'b1;
				target = base_imm; // bit 0 cleared in pc_unit
			end
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		mem.req   = 1'b0;
		mem.wen   = 1'b0;
		mem.addr  = base_imm;
		mem.wdata = src2;
		mem.wmask = 4'h0;
		case (dec.op)
			op_lw, op_lbu: mem.req = 1'b1;
			op_sb: begin
				mem.req = 1'b1;
				mem.wen = 1'b1;
				mem.wmask = 4'h1;
			end
			op_sh: begin
				mem.req = 1'b1;
				mem.wen = 1'b1;
				mem.wmask = 4'h3;
			end
			op_sw: begin
				mem.req = 1'b1;
				mem.wen = 1'b1;
				mem.wmask = 4'hf;
			end
			default: mem.req = 1'b0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        wen,
	input  logic [31:0] wdata,
	output logic [31:0] src1,
	output logic [31:0] src2
);

	logic [31:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output mem_req_t    dmem,
	input  logic [31:0] dmem_rdata,
	output commit_t     commit,
	output logic        halted,
	output logic        trap
);

	state_e      state;
	decoded_t    dec;
	mem_req_t    mem_req;
	logic [31:0] ir;
	logic [31:0] pc;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] value;
	logic [31:0] target;
	logic [31:0] load_data;
	logic        taken;
	logic        instr_latch;
	logic        pc_step;
	logic        rf_wen;
	logic        mem_go;
	logic        commit_valid;

	always_ff @(posedge clk) begin
		if (instr_latch)
			ir <= imem_rdata; // held until the next fetch
	end

	assign imem_addr = pc;
	assign load_data = (state == st_wb) ? dmem_rdata : '0; // read data lands in wb

	pc_unit i_pc_unit (
		.clk(clk), .rst_n(rst_n), .step(pc_step), .load(taken), .target(target), .pc(pc)
	);

	core_ctrl i_core_ctrl (
		.clk(clk), .rst_n(rst_n), .op(dec.op), .state(state),
		.instr_latch(instr_latch), .pc_step(pc_step), .rf_wen(rf_wen), .mem_go(mem_go),
		.commit_valid(commit_valid), .halted(halted), .trap(trap)
	);

	decoder i_decoder (.instr(ir), .dec(dec));

	exu i_exu (
		.dec(dec), .src1(src1), .src2(src2), .pc(pc), .rdata(load_data),
		.value(value), .taken(taken), .target(target), .mem(mem_req)
	);

	reg_file i_reg_file (
		.clk(clk), .rst_n(rst_n), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
		.wen(rf_wen), .wdata(value), .src1(src1), .src2(src2)
	);

	always_comb begin
		dmem = mem_req;
		dmem.req = mem_req.req & mem_go; // one-cycle pulse in mem
	end

	always_comb begin
		commit.valid = commit_valid;
		commit.pc    = pc;
		commit.rd    = dec.rd;
		commit.value = value;
		commit.wen   = rf_wen && (dec.rd != 5'd0); // x0 writes dropped
	end

endmodule

// File: bench/core_chk.sv
`timescale 1ns/1ps

module core_chk import rv_isa_pkg::*, core_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input state_e   state,
	input op_e      op,
	input commit_t  commit,
	input mem_req_t dmem,
	input logic     halted,
	input logic     trap
);

	int fails = 0;
	logic plain_op;
	logic writes_rd;

	assign plain_op = !(op inside {op_lw, op_lbu, op_sb, op_sh, op_sw, op_ebreak, op_illegal});
	assign writes_rd = !(op inside {op_beq, op_bne, op_bge, op_sb, op_sh, op_sw,
		op_ebreak, op_illegal});

	a_commit_gap: assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |=> !commit.valid ##1 !commit.valid)
		else begin fails++; $error("commits closer than 3 cycles"); end

	// exec of a plain op commits next cycle, so back to back gap is 3
	a_plain_three: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_exec && plain_op) |=> commit.valid)
		else begin fails++; $error("plain op did not commit after exec"); end

	a_commit_wen: assert property (@(posedge clk) disable iff (!rst_n)
		commit.valid |-> commit.wen == (writes_rd && commit.rd != 5'd0)) // x0 never written
		else begin fails++; $error("commit write enable wrong for this op"); end

	a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		dmem.req |=> !dmem.req)
		else begin fails++; $error("dmem request longer than one cycle"); end

	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else begin fails++; $error("halted dropped"); end

	a_ebreak_halt: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_exec && op == op_ebreak) |=> halted && !trap)
		else begin fails++; $error("ebreak did not halt cleanly"); end

	a_illegal_trap: assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_exec && op == op_illegal) |=> halted && trap)
		else begin fails++; $error("illegal word did not trap"); end

endmodule

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb import rv_isa_pkg::*, core_pkg::*;;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	mem_req_t    dmem;
	logic [31:0] dmem_rdata;
	commit_t     commit;
	logic        halted;
	logic        trap;

	logic [31:0] imem [0:255];
	logic [31:0] mem [0:127];
	logic [31:0] pre [0:127]; // copy of the random preload
	logic [31:0] shadow [0:31]; // last committed value per register
	mem_req_t    req_q;
	integer      seed;
	int          n;
	int          errors;
	int          cycles;
	int          limit;
	logic [31:0] pc_jal;
	logic        second_run;
	logic        bad_commit;

	core_top i_core_top (.*);

	bind core_top core_chk i_core_chk (
		.clk(clk), .rst_n(rst_n), .state(state), .op(dec.op),
		.commit(commit), .dmem(dmem), .halted(halted), .trap(trap)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign imem_rdata = imem[imem_addr[9:2]]; // same-cycle fetch

	always @(posedge clk) begin
		req_q = dmem;
		#1;
		if (req_q.req && req_q.wen) begin
			for (int b = 0; b < 4; b++)
				if (req_q.wmask[b])
					mem[req_q.addr[8:2]][b*8 +: 8] = req_q.wdata[b*8 +: 8];
		end else if (req_q.req) begin
			dmem_rdata = mem[req_q.addr[8:2]]; // visible in wb
		end
	end

	always @(posedge clk) begin
		if (commit.valid && commit.wen)
			shadow[commit.rd] = commit.value;
		if (second_run && commit.valid && commit.pc == 32'd4)
			bad_commit = 1'b1;
	end

	function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base is always x0
	endfunction

	function automatic logic [31:0] btype(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jtype(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] rtype(logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd);
		return {7'b0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	task automatic emit(logic [31:0] word);
		imem[n] = word;
		n++;
	endtask

	task automatic branch_case(logic [31:0] br, logic is_taken, logic [11:0] k);
		emit(br);
		if (is_taken)
			emit(itype(12'd64, 5'd11, 3'b000, 5'd11, 7'b0010011)); // wrong path
		emit(itype(k, 5'd11, 3'b000, 5'd11, 7'b0010011));
	endtask

	task automatic check_word(string name, int idx, logic [31:0] exp);
		assert (mem[idx] == exp) else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, mem[idx]);
		end
	endtask

	task automatic check_reg(string name, int r, logic [31:0] exp);
		assert (shadow[r] == exp) else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, shadow[r]);
		end
	endtask

	task automatic reset_and_run();
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		limit = n * 4 * 2;
		cycles = 0;
		while (!halted && cycles < limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			$display("sim failed");
			$finish;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		dmem_rdata = '0;
		errors = 0;
		second_run = 1'b0;
		bad_commit = 1'b0;
		seed = 9359;
		n = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = '0;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		for (int i = 0; i < 128; i++) begin
			mem[i] = $random(seed);
			pre[i] = mem[i];
		end

		emit({20'h12345, 5'd1, 7'b0110111});                  // lui x1
		emit({20'h00001, 5'd2, 7'b0010111});                  // auipc x2 at pc 4
		emit(itype(12'h678, 5'd1, 3'b000, 5'd3, 7'b0010011)); // addi
		emit(itype(12'hfff, 5'd3, 3'b011, 5'd4, 7'b0010011)); // sltiu vs all ones
		emit(itype(12'd4, 5'd3, 3'b001, 5'd5, 7'b0010011));   // slli
		emit(rtype(5'd5, 5'd3, 3'b000, 5'd6));                // add
		emit(itype(12'd3, 5'd0, 3'b000, 5'd7, 7'b0010011));
		emit(rtype(5'd7, 5'd3, 3'b001, 5'd8));                // sll
		emit(itype(12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011));   // addi into x0, dropped
		for (int r = 1; r <= 8; r++)
			emit(stype(12'h100 + 12'((r - 1) * 4), 5'(r), 3'b010));
		emit(itype(12'd0, 5'd0, 3'b010, 5'd9, 7'b0000011));   // lw
		emit(itype(12'd5, 5'd0, 3'b100, 5'd10, 7'b0000011));  // lbu
		emit(stype(12'h120, 5'd9, 3'b010));
		emit(stype(12'h124, 5'd10, 3'b010));
		emit(stype(12'd8, 5'd3, 3'b000));                     // sb
		emit(stype(12'd12, 5'd3, 3'b001));                    // sh
		emit(itype(12'd0, 5'd0, 3'b000, 5'd11, 7'b0010011));
		branch_case(btype(13'd8, 5'd3, 5'd3, 3'b000), 1'b1, 12'd1);
		branch_case(btype(13'd8, 5'd4, 5'd3, 3'b000), 1'b0, 12'd2);
		branch_case(btype(13'd8, 5'd4, 5'd3, 3'b001), 1'b1, 12'd4);
		branch_case(btype(13'd8, 5'd3, 5'd3, 3'b001), 1'b0, 12'd8);
		branch_case(btype(13'd8, 5'd4, 5'd3, 3'b101), 1'b1, 12'd16);
		branch_case(btype(13'd8, 5'd4, 5'd8, 3'b101), 1'b0, 12'd32); // negative rs1
		pc_jal = 32'(n * 4);
		emit(jtype(21'd8, 5'd12));
		emit(itype(12'd64, 5'd11, 3'b000, 5'd11, 7'b0010011));
		emit(itype(12'd12, 5'd12, 3'b000, 5'd13, 7'b1100111)); // jalr to pc_jal + 16
		emit(itype(12'd64, 5'd11, 3'b000, 5'd11, 7'b0010011));
		emit(itype(12'd128, 5'd11, 3'b000, 5'd11, 7'b0010011));
		emit(stype(12'h128, 5'd11, 3'b010));
		emit(stype(12'h12c, 5'd12, 3'b010));
		emit(stype(12'h130, 5'd13, 3'b010));
		emit(ebreak_word);

		reset_and_run();
		assert (!trap) else begin
			errors++;
			$display("trap raised on a legal program");
		end
		check_word("lui", 64, 32'h1234_5000);
		check_word("auipc", 65, 32'h0000_1004);
		check_word("addi", 66, 32'h1234_5678);
		check_word("sltiu", 67, 32'd1);
		check_word("slli", 68, 32'h2345_6780);
		check_word("add", 69, 32'h3579_bdf8);
		check_word("addi_small", 70, 32'd3);
		check_word("sll", 71, 32'h91a2_b3c0);
		check_word("lw", 72, pre[0]);
		check_word("lbu", 73, {24'b0, pre[1][15:8]});
		check_word("sb", 2, {pre[2][31:8], 8'h78});
		check_word("sh", 3, {pre[3][31:16], 16'h5678});
		check_word("untouched", 4, pre[4]);
		check_word("branch_marker", 74, 32'd191);
		check_word("jal_link", 75, pc_jal + 32'd4);
		check_word("jalr_link", 76, pc_jal + 32'd12);
		check_reg("lui_commit", 1, 32'h1234_5000);
		check_reg("sll_commit", 8, 32'h91a2_b3c0);
		check_reg("lw_commit", 9, pre[0]);
		check_reg("lbu_commit", 10, {24'b0, pre[1][15:8]});
		check_reg("marker_commit", 11, 32'd191);
		check_reg("jal_commit", 12, pc_jal + 32'd4);
		check_reg("jalr_commit", 13, pc_jal + 32'd12);

		n = 0;
		emit(itype(12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011));
		emit(32'hffff_ffff);
		second_run = 1'b1;
		reset_and_run();
		assert (trap && !bad_commit) else begin
			errors++;
			$display("illegal word did not trap cleanly");
		end

		$display("errors: %0d checks, %0d assertions", errors, i_core_top.i_core_chk.fails);
		if (errors == 0 && i_core_top.i_core_chk.fails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: list.f
src/rv_isa_pkg.sv
src/core_pkg.sv
src/pc_unit.sv
src/core_ctrl.sv
src/decoder.sv
src/exu.sv
src/reg_file.sv
src/core_top.sv
bench/core_chk.sv
bench/core_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = core_tb
RTL_TOP   = core_top
FILELIST  = list.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
